//--- hdl/activity_stretch.sv
// ------------------------------
// Activity indication from transmit beats
// Held low while link is down
// ------------------------------
`timescale 1ns/1ns

module activity_stretch (
   input  logic bus_clk,
   input  logic reset_i,
   input  logic link_up_i,
   input  logic beat_i,
   output logic activity_o
);

   import regs_pkg::*;

   logic [STRETCH_CNT_W-1:0] cnt_q;  // Cycles of activity left

   always_ff @(posedge bus_clk) begin
      if (reset_i || !link_up_i) begin
         cnt_q <= '0;
      end else if (beat_i) begin
         cnt_q <= STRETCH_CNT_W'(STRETCH_CYCLES);  // Retrigger
      end else if (cnt_q != '0) begin
         cnt_q <= cnt_q - STRETCH_CNT_W'(1);
      end
   end

   assign activity_o = (cnt_q != '0);

endmodule

//--- hdl/link_flush.sv
// ------------------------------
// Drops whole transmit packets while the link is down
// Mode only switches between packets, never mid-packet
// ------------------------------
`timescale 1ns/1ns

module link_flush (
   input  logic                         bus_clk,
   input  logic                         reset_i,
   input  logic                         link_up_i,   // Synchronized link state
   // From device
   input  logic [stream_pkg::TDATA_W-1:0] s_tdata_i,
   input  logic [stream_pkg::TUSER_W-1:0] s_tuser_i,
   input  logic                         s_tlast_i,
   input  logic                         s_tvalid_i,
   output logic                         s_tready_o,
   // To MAC
   output logic [stream_pkg::TDATA_W-1:0] m_tdata_o,
   output logic [stream_pkg::TUSER_W-1:0] m_tuser_o,
   output logic                         m_tlast_o,
   output logic                         m_tvalid_o,
   input  logic                         m_tready_i
);

   import stream_pkg::*;

   flush_state_e flush_state_q;
   logic         pkt_open_q;   // Beat seen, last not yet
   logic         beat;
   logic         mode_update;  // Packet boundary

   // ------------------------------
   // Datapath, no pipeline
   // ------------------------------
   assign m_tdata_o  = s_tdata_i;
   assign m_tuser_o  = s_tuser_i;
   assign m_tlast_o  = s_tlast_i;
   assign m_tvalid_o = (flush_state_q == FLUSH_PASS) ? s_tvalid_i : 1'b0;
   assign s_tready_o = (flush_state_q == FLUSH_DROP) ? 1'b1 : m_tready_i;  // Sink all in drop

   assign beat = s_tvalid_i & s_tready_o;

   // Last beat closes a packet, or nothing open and nothing moving
   assign mode_update = (beat & s_tlast_i) | (~pkt_open_q & ~beat);

   always_ff @(posedge bus_clk) begin
      if (reset_i) begin
         pkt_open_q <= 1'b0;
      end else if (beat) begin
         pkt_open_q <= ~s_tlast_i;  // Open until last
      end
   end

   always_ff @(posedge bus_clk) begin
      if (reset_i) begin
         flush_state_q <= FLUSH_PASS;
      end else if (mode_update) begin
         flush_state_q <= link_up_i ? FLUSH_PASS : FLUSH_DROP;
      end
   end

   // ------------------------------
   // Checks
   // ------------------------------
   a_drop_sinks : assert property (@(posedge bus_clk) disable iff (reset_i)
      (flush_state_q == FLUSH_DROP) |-> (!m_tvalid_o && s_tready_o))
      else $error("Flush stage leaked a beat while dropping");

endmodule

//--- hdl/regs_pkg.sv
// ------------------------------
// Register map and status layout of the port
// Unlisted addresses read zero, only address 0 is writable
// ------------------------------
package regs_pkg;

   // Bus geometry
   localparam int WB_ADDR_W = 8;
   localparam int WB_DATA_W = 32;

   // Register addresses
   typedef enum logic [WB_ADDR_W-1:0] {
      REG_CORE_CTRL_STATUS = 8'd0,  // Write control, read status
      REG_OVERRUNS         = 8'd1,
      REG_CKSUM_ERRS       = 8'd2,
      REG_BIST_SAMPS       = 8'd3,  // Scaled by 2^SAMPS_SHIFT
      REG_BIST_ERRS        = 8'd4   // Low word only
   } reg_addr_e;

   // ------------------------------
   // Control word fields
   // ------------------------------
   localparam int CTRL_CHECKER_EN_BIT = 0;
   localparam int CTRL_GEN_EN_BIT     = 1;
   localparam int CTRL_LOOPBACK_BIT   = 2;
   localparam int CTRL_GEN_RATE_LSB   = 3;  // Rate in bits 8:3
   localparam int CTRL_PHY_RESET_BIT  = 9;
   localparam int CTRL_MAC_CLEAR_BIT  = 10;
   localparam int CTRL_W              = 11;
   localparam int GEN_RATE_W          = 6;

   // BIST counters
   localparam int BIST_CNT_W  = 48;
   localparam int SAMPS_SHIFT = 16;
   localparam int LOCK_LAT_W  = 20;
   localparam int LAT_RD_W    = 16;  // Top bits of latency counter shown

   // ------------------------------
   // Status word bits, rest zero
   // ------------------------------
   localparam int STAT_CHANNEL_UP_BIT = 0;
   localparam int STAT_HARD_ERR_BIT   = 1;
   localparam int STAT_SOFT_ERR_BIT   = 2;
   localparam int STAT_LOCKED_BIT     = 3;
   localparam int STAT_LAT_LSB        = 4;  // Latency in bits 19:4
   localparam int STAT_CRIT_BIT       = 25;

   // Flag synchronizers and activity stretch
   localparam int SYNC_STAGES    = 2;
   localparam int STRETCH_CYCLES = 16;
   localparam int STRETCH_CNT_W  = $clog2(STRETCH_CYCLES + 1);

endpackage

//--- hdl/sfp_port_core.sv
// ------------------------------
// Bus-clock housekeeping of one SFP+ port
// PHY and MAC sit outside, their flags and counters come in as ports
// ------------------------------
`timescale 1ns/1ns

module sfp_port_core (
   input  logic                               bus_clk,
   input  logic                               reset_i,
   // Transmit stream from device
   input  logic [stream_pkg::TDATA_W-1:0]     s_tdata_i,
   input  logic [stream_pkg::TUSER_W-1:0]     s_tuser_i,
   input  logic                               s_tlast_i,
   input  logic                               s_tvalid_i,
   output logic                               s_tready_o,
   // Transmit stream to MAC
   output logic [stream_pkg::TDATA_W-1:0]     m_tdata_o,
   output logic [stream_pkg::TUSER_W-1:0]     m_tuser_o,
   output logic                               m_tlast_o,
   output logic                               m_tvalid_o,
   input  logic                               m_tready_i,
   // Register bus
   input  logic [regs_pkg::WB_ADDR_W-1:0]     wb_adr_i,
   input  logic [regs_pkg::WB_DATA_W-1:0]     wb_dat_i,
   input  logic                               wb_cyc_i,
   input  logic                               wb_stb_i,
   input  logic                               wb_we_i,
   output logic                               wb_ack_o,
   output logic [regs_pkg::WB_DATA_W-1:0]     wb_dat_o,
   // PHY and MAC flags, asynchronous
   input  logic                               channel_up_i,
   input  logic                               hard_err_i,
   input  logic                               soft_err_i,
   input  logic                               crit_err_i,
   // MAC counters and BIST, on bus_clk
   input  logic                               bist_locked_i,
   input  logic [regs_pkg::WB_DATA_W-1:0]     overruns_i,
   input  logic [regs_pkg::WB_DATA_W-1:0]     cksum_errs_i,
   input  logic [regs_pkg::BIST_CNT_W-1:0]    bist_samps_i,
   input  logic [regs_pkg::BIST_CNT_W-1:0]    bist_errs_i,
   // Control to PHY and MAC
   output logic                               mac_clear_o,
   output logic                               phy_reset_o,
   output logic                               bist_loopback_o,
   output logic                               bist_gen_en_o,
   output logic                               bist_checker_en_o,
   output logic [regs_pkg::GEN_RATE_W-1:0]    bist_gen_rate_o,
   // Front panel
   output logic                               link_up_o,
   output logic                               activity_o
);

   import regs_pkg::*;

   logic                 channel_up_sync;
   logic [WB_DATA_W-1:0] core_status;
   logic                 tx_beat;         // Device-side transfer

   assign tx_beat   = s_tvalid_i & s_tready_o;
   assign link_up_o = channel_up_sync;

   // ------------------------------
   // Transmit path
   // ------------------------------
   link_flush link_flush_i (
      .bus_clk    (bus_clk),
      .reset_i    (reset_i),
      .link_up_i  (channel_up_sync),
      .s_tdata_i  (s_tdata_i),
      .s_tuser_i  (s_tuser_i),
      .s_tlast_i  (s_tlast_i),
      .s_tvalid_i (s_tvalid_i),
      .s_tready_o (s_tready_o),
      .m_tdata_o  (m_tdata_o),
      .m_tuser_o  (m_tuser_o),
      .m_tlast_o  (m_tlast_o),
      .m_tvalid_o (m_tvalid_o),
      .m_tready_i (m_tready_i)
   );

   activity_stretch activity_stretch_i (
      .bus_clk    (bus_clk),
      .reset_i    (reset_i),
      .link_up_i  (channel_up_sync),
      .beat_i     (tx_beat),
      .activity_o (activity_o)
   );

   // ------------------------------
   // Status and registers
   // ------------------------------
   status_monitor status_monitor_i (
      .bus_clk       (bus_clk),
      .reset_i       (reset_i),
      .channel_up_i  (channel_up_i),
      .hard_err_i    (hard_err_i),
      .soft_err_i    (soft_err_i),
      .crit_err_i    (crit_err_i),
      .bist_locked_i (bist_locked_i),
      .checker_en_i  (bist_checker_en_o),  // Control fields fed back
      .mac_clear_i   (mac_clear_o),
      .channel_up_o  (channel_up_sync),
      .core_status_o (core_status)
   );

   wb_regs wb_regs_i (
      .bus_clk           (bus_clk),
      .reset_i           (reset_i),
      .wb_adr_i          (wb_adr_i),
      .wb_dat_i          (wb_dat_i),
      .wb_cyc_i          (wb_cyc_i),
      .wb_stb_i          (wb_stb_i),
      .wb_we_i           (wb_we_i),
      .wb_ack_o          (wb_ack_o),
      .wb_dat_o          (wb_dat_o),
      .core_status_i     (core_status),
      .overruns_i        (overruns_i),    // Counters straight through
      .cksum_errs_i      (cksum_errs_i),
      .bist_samps_i      (bist_samps_i),
      .bist_errs_i       (bist_errs_i),
      .mac_clear_o       (mac_clear_o),
      .phy_reset_o       (phy_reset_o),
      .bist_loopback_o   (bist_loopback_o),
      .bist_gen_en_o     (bist_gen_en_o),
      .bist_checker_en_o (bist_checker_en_o),
      .bist_gen_rate_o   (bist_gen_rate_o)
   );

endmodule

//--- hdl/status_monitor.sv
// ------------------------------
// PHY and MAC flag synchronizers and status word
// Flags are asynchronous, bist_locked_i must already be on bus_clk
// ------------------------------
`timescale 1ns/1ns

module status_monitor (
   input  logic                           bus_clk,
   input  logic                           reset_i,
   input  logic                           channel_up_i,   // Async
   input  logic                           hard_err_i,     // Async
   input  logic                           soft_err_i,     // Async
   input  logic                           crit_err_i,     // Async
   input  logic                           bist_locked_i,
   input  logic                           checker_en_i,
   input  logic                           mac_clear_i,
   output logic                           channel_up_o,
   output logic [regs_pkg::WB_DATA_W-1:0] core_status_o
);

   import regs_pkg::*;

   // One shift chain per flag, stage 0 is the metastable one
   logic [SYNC_STAGES-1:0][3:0] sync_q;
   logic                        up_sync;
   logic                        hard_sync;
   logic                        soft_sync;
   logic                        crit_sync;
   logic                        crit_q;    // Sticky critical error
   logic [LOCK_LAT_W-1:0]       lat_q;     // Cycles from enable to lock

   // ------------------------------
   // Synchronizers
   // ------------------------------
   always_ff @(posedge bus_clk) begin
      if (reset_i) begin
         sync_q <= '0;
      end else begin
         sync_q[0] <= {crit_err_i, soft_err_i, hard_err_i, channel_up_i};
         for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign {crit_sync, soft_sync, hard_sync, up_sync} = sync_q[SYNC_STAGES-1];
   assign channel_up_o = up_sync;

   // Critical latch, clear wins over set
   always_ff @(posedge bus_clk) begin
      if (reset_i || mac_clear_i) begin
         crit_q <= 1'b0;
      end else if (crit_sync) begin
         crit_q <= 1'b1;
      end
   end

   // ------------------------------
   // Lock latency
   // ------------------------------
   always_ff @(posedge bus_clk) begin
      if (reset_i) begin
         lat_q <= '0;
      end else if (!checker_en_i && !bist_locked_i) begin
         lat_q <= '0;                          // Idle, ready for next run
      end else if (checker_en_i && !bist_locked_i) begin
         lat_q <= lat_q + LOCK_LAT_W'(1);      // Hunting
      end
   end

   // Status word, unused bits stay zero
   always_comb begin
      core_status_o = '0;
      core_status_o[STAT_CHANNEL_UP_BIT] = up_sync;
      core_status_o[STAT_HARD_ERR_BIT]   = hard_sync;
      core_status_o[STAT_SOFT_ERR_BIT]   = soft_sync;
      core_status_o[STAT_LOCKED_BIT]     = bist_locked_i;
      core_status_o[STAT_LAT_LSB +: LAT_RD_W] = lat_q[LOCK_LAT_W-1 -: LAT_RD_W];
      core_status_o[STAT_CRIT_BIT]       = crit_q;
   end

endmodule

//--- hdl/stream_pkg.sv
// ------------------------------
// Transmit stream widths and flush modes
// 64-bit data with 4 user bits, no keep or strobe
// ------------------------------
package stream_pkg;

   localparam int TDATA_W = 64;  // Transmit data word
   localparam int TUSER_W = 4;   // Per-beat user field

   // Flush stage mode, changed only between packets
   typedef enum logic {
      FLUSH_PASS = 1'b0,  // Link up, beats go to MAC
      FLUSH_DROP = 1'b1   // Link down, beats swallowed
   } flush_state_e;

endpackage

//--- hdl/wb_regs.sv
// ------------------------------
// Wishbone control and read-back registers
// Single-cycle ack one clock after strobe, no wait states
// ------------------------------
`timescale 1ns/1ns

module wb_regs (
   input  logic                               bus_clk,
   input  logic                               reset_i,
   // Wishbone slave
   input  logic [regs_pkg::WB_ADDR_W-1:0]     wb_adr_i,
   input  logic [regs_pkg::WB_DATA_W-1:0]     wb_dat_i,
   input  logic                               wb_cyc_i,
   input  logic                               wb_stb_i,
   input  logic                               wb_we_i,
   output logic                               wb_ack_o,
   output logic [regs_pkg::WB_DATA_W-1:0]     wb_dat_o,
   // Read-back sources
   input  logic [regs_pkg::WB_DATA_W-1:0]     core_status_i,
   input  logic [regs_pkg::WB_DATA_W-1:0]     overruns_i,
   input  logic [regs_pkg::WB_DATA_W-1:0]     cksum_errs_i,
   input  logic [regs_pkg::BIST_CNT_W-1:0]    bist_samps_i,
   input  logic [regs_pkg::BIST_CNT_W-1:0]    bist_errs_i,
   // Control fields
   output logic                               mac_clear_o,
   output logic                               phy_reset_o,
   output logic                               bist_loopback_o,
   output logic                               bist_gen_en_o,
   output logic                               bist_checker_en_o,
   output logic [regs_pkg::GEN_RATE_W-1:0]    bist_gen_rate_o
);

   import regs_pkg::*;

   reg_addr_e            addr;
   logic                 req;       // New access this cycle
   logic                 ack_q;
   logic [CTRL_W-1:0]    ctrl_q;
   logic [WB_DATA_W-1:0] rd_data;
   logic [WB_DATA_W-1:0] rd_data_q;

   assign addr = reg_addr_e'(wb_adr_i);
   assign req  = wb_cyc_i & wb_stb_i & ~ack_q;  // Ignore strobe during own ack

   // ------------------------------
   // Handshake and control register
   // ------------------------------
   always_ff @(posedge bus_clk) begin
      if (reset_i) begin
         ack_q  <= 1'b0;
         ctrl_q <= '0;
      end else begin
         ack_q <= req;
         if (req && wb_we_i && (addr == REG_CORE_CTRL_STATUS)) begin
            ctrl_q <= wb_dat_i[CTRL_W-1:0];  // Upper data bits ignored
         end
      end
   end

   // Read-back mux
   always_comb begin
      case (addr)
         REG_CORE_CTRL_STATUS: rd_data = core_status_i;
         REG_OVERRUNS:         rd_data = overruns_i;
         REG_CKSUM_ERRS:       rd_data = cksum_errs_i;
         REG_BIST_SAMPS:       rd_data = bist_samps_i[SAMPS_SHIFT +: WB_DATA_W];  // 47:16
         REG_BIST_ERRS:        rd_data = bist_errs_i[WB_DATA_W-1:0];              // Unscaled
         default:              rd_data = '0;
      endcase
   end

   // Captured with the ack, valid while ack high
   always_ff @(posedge bus_clk) begin
      if (req) begin
         rd_data_q <= rd_data;
      end
   end

   assign wb_ack_o = ack_q;
   assign wb_dat_o = rd_data_q;

   // ------------------------------
   // Control field split
   // ------------------------------
   assign bist_checker_en_o = ctrl_q[CTRL_CHECKER_EN_BIT];
   assign bist_gen_en_o     = ctrl_q[CTRL_GEN_EN_BIT];
   assign bist_loopback_o   = ctrl_q[CTRL_LOOPBACK_BIT];
   assign bist_gen_rate_o   = ctrl_q[CTRL_GEN_RATE_LSB +: GEN_RATE_W];
   assign phy_reset_o       = ctrl_q[CTRL_PHY_RESET_BIT];
   assign mac_clear_o       = ctrl_q[CTRL_MAC_CLEAR_BIT];

   // One ack per access even with strobe held
   a_ack_pulse : assert property (@(posedge bus_clk) disable iff (reset_i)
      wb_ack_o |=> !wb_ack_o)
      else $error("Wishbone ack held for two cycles");

endmodule

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_sfp_port_core -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
   exit 1
fi
if ! grep -q "\*\*\* PASSED \*\*\*" sim.log; then
   exit 1
fi
exit 0

//--- tb.f
hdl/stream_pkg.sv
hdl/regs_pkg.sv
hdl/link_flush.sv
hdl/wb_regs.sv
hdl/status_monitor.sv
hdl/activity_stretch.sv
hdl/sfp_port_core.sv
tb/tb_sfp_port_core.sv

//--- tb/tb_sfp_port_core.sv
// ------------------------------
// Table-driven testbench of the SFP+ port housekeeping
// Inputs change on the falling edge, outputs sampled mid low phase
// ------------------------------
`timescale 1ns/1ns

module tb_sfp_port_core;

   import stream_pkg::*;
   import regs_pkg::*;

   // Step kinds
   localparam int K_FLAGS   = 0;  // a = {locked, crit, soft, hard, up}, d = cycles
   localparam int K_WRITE   = 1;  // a = addr, d = data, exp = control outputs
   localparam int K_READ    = 2;  // a = addr, exp and mask on read data
   localparam int K_PKT     = 3;  // a = 0 drop, 1 pass, 2 drop with link rising
   localparam int K_ACT     = 4;  // a = 1 link up, 0 link down
   localparam int K_LAT     = 5;  // Two latency reads must match
   localparam int MAX_STEPS = 40;
   localparam int TMO       = 200;

   logic                 bus_clk;
   logic                 reset_i;
   logic [TDATA_W-1:0]   s_tdata_i;
   logic [TUSER_W-1:0]   s_tuser_i;
   logic                 s_tlast_i, s_tvalid_i, s_tready_o;
   logic [TDATA_W-1:0]   m_tdata_o;
   logic [TUSER_W-1:0]   m_tuser_o;
   logic                 m_tlast_o, m_tvalid_o, m_tready_i;
   logic [WB_ADDR_W-1:0] wb_adr_i;
   logic [WB_DATA_W-1:0] wb_dat_i, wb_dat_o;
   logic                 wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   logic                 channel_up_i, hard_err_i, soft_err_i, crit_err_i, bist_locked_i;
   logic [WB_DATA_W-1:0] overruns_i, cksum_errs_i;
   logic [BIST_CNT_W-1:0] bist_samps_i, bist_errs_i;
   logic                 mac_clear_o, phy_reset_o, bist_loopback_o;
   logic                 bist_gen_en_o, bist_checker_en_o;
   logic [GEN_RATE_W-1:0] bist_gen_rate_o;
   logic                 link_up_o, activity_o;

   // Stimulus table
   int          n_steps;
   int          kind_t [MAX_STEPS];
   string       name_t [MAX_STEPS];
   logic [31:0] a_t    [MAX_STEPS];
   logic [31:0] d_t    [MAX_STEPS];
   logic [31:0] exp_t  [MAX_STEPS];
   logic [31:0] mask_t [MAX_STEPS];

   int          errors;
   int          tests_ok;
   int          tests_bad;
   logic [15:0] lfsr_q;

   sfp_port_core sfp_port_core_i (.*);

   initial begin
      bus_clk = 1'b0;
      forever #4 bus_clk = ~bus_clk;
   end

   // ------------------------------
   // Helpers
   // ------------------------------
   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      if (exp !== act) begin
         $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[62:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      end
      return val;
   endfunction

   task automatic add_step(input int k, input string n, input logic [31:0] a,
                           input logic [31:0] d, input logic [31:0] e,
                           input logic [31:0] m);
      kind_t[n_steps] = k;
      name_t[n_steps] = n;
      a_t[n_steps]    = a;
      d_t[n_steps]    = d;
      exp_t[n_steps]  = e;
      mask_t[n_steps] = m;
      n_steps++;
   endtask

   task automatic set_flags(input logic [4:0] f);
      {bist_locked_i, crit_err_i, soft_err_i, hard_err_i, channel_up_i} = f;
   endtask

   // One Wishbone access, waits for ack with a timeout
   task automatic wb_access(input string name, input logic we, input logic [7:0] adr,
                            input logic [31:0] dat, output logic [31:0] rdat);
      int t;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = dat;
      rdat     = '0;
      t        = 0;
      do begin
         @(negedge bus_clk);
         t++;
      end while (!wb_ack_o && t < TMO);
      if (!wb_ack_o) begin
         $display("%s: no Wishbone ack within %0d cycles", name, TMO);
         errors++;
      end
      rdat     = wb_dat_o;  // Valid during ack
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   // Sends a 4-beat packet, random MAC ready, records MAC side transfers
   task automatic send_packet(input string name, input logic [31:0] mode);
      logic [63:0] dat [4];
      logic [63:0] usr [4];
      logic [63:0] r;
      logic [68:0] got [$];
      logic        acc;
      int          t;
      for (int b = 0; b < 4; b++) begin
         dat[b]     = rand_bits(TDATA_W);
         usr[b]     = rand_bits(TUSER_W);
         s_tdata_i  = dat[b];
         s_tuser_i  = usr[b][TUSER_W-1:0];
         s_tlast_i  = (b == 3);
         s_tvalid_i = 1'b1;
         if (mode == 2 && b == 1) channel_up_i = 1'b1;  // Rise mid packet
         t   = 0;
         acc = 1'b0;
         forever begin
            r = rand_bits(1);
            m_tready_i = r[0];
            #2;
            // Drop mode sinks everything, pass mode follows the MAC
            check_value({name, " device ready"}, (mode == 1) ? m_tready_i : 1'b1,
                        s_tready_o);
            acc = s_tvalid_i && s_tready_o;  // Transfer at the coming edge
            if (m_tvalid_o && m_tready_i) got.push_back({m_tlast_o, m_tuser_o, m_tdata_o});
            @(negedge bus_clk);
            t++;
            if (acc || t >= TMO) break;
         end
         if (!acc) begin
            $display("%s: beat %0d not accepted by flush stage", name, b);
            errors++;
         end
      end
      s_tvalid_i = 1'b0;
      s_tlast_i  = 1'b0;
      m_tready_i = 1'b0;
      check_value({name, " beats at MAC"}, (mode == 1) ? 4 : 0, got.size());
      if (mode == 1 && got.size() == 4) begin
         for (int b = 0; b < 4; b++) begin
            check_value({name, " beat data"}, dat[b], got[b][63:0]);
            check_value({name, " beat last and user"}, {b == 3, usr[b][3:0]},
                        got[b][68:64]);
         end
      end
   endtask

   // Single beat, then watch the activity output
   task automatic check_activity(input string name, input logic [31:0] up);
      int t;
      int high;
      s_tvalid_i = 1'b1;
      s_tlast_i  = 1'b1;
      m_tready_i = 1'b1;
      @(negedge bus_clk);
      s_tvalid_i = 1'b0;
      s_tlast_i  = 1'b0;
      m_tready_i = 1'b0;
      t    = 0;
      high = 0;
      while (t < STRETCH_CYCLES + 2) begin
         #2;
         if (activity_o) high++;
         if (!activity_o && up && (high > 0 || t >= 2)) break;  // Low seen
         @(negedge bus_clk);
         t++;
      end
      if (up) begin
         check_value({name, " enough active cycles"}, 1, high >= STRETCH_CYCLES - 1);
         check_value({name, " fell in time"}, 0, activity_o);
      end else begin
         check_value({name, " active cycles"}, 0, high);
      end
   endtask

   // ------------------------------
   // Table
   // ------------------------------
   task automatic build_table();
      n_steps = 0;
      add_step(K_FLAGS, "link up",        5'b00001, 3, 0, 0);
      add_step(K_PKT,   "packet pass",    1, 0, 0, 0);
      add_step(K_PKT,   "packet pass 2",  1, 0, 0, 0);
      add_step(K_WRITE, "control word",   0, 32'hFFFF_F2F2, 32'h2F2, 0);
      add_step(K_WRITE, "control clear",  0, 0, 0, 0);
      add_step(K_FLAGS, "flags a",        5'b10011, 3, 0, 0);
      add_step(K_READ,  "status a",       0, 0, 32'h0000_000B, 32'hFFFF_FFFF);
      add_step(K_FLAGS, "flags b",        5'b00101, 3, 0, 0);
      add_step(K_READ,  "status b",       0, 0, 32'h0000_0005, 32'hFFFF_FFFF);
      add_step(K_READ,  "overruns",       1, 0, 32'h1234_5678, 32'hFFFF_FFFF);
      add_step(K_READ,  "cksum errs",     2, 0, 32'h0000_0ABC, 32'hFFFF_FFFF);
      add_step(K_READ,  "bist samps",     3, 0, 32'h0123_4567, 32'hFFFF_FFFF);
      add_step(K_READ,  "bist errs",      4, 0, 32'hBA98_7654, 32'hFFFF_FFFF);
      add_step(K_READ,  "unmapped",       7, 0, 0, 32'hFFFF_FFFF);
      add_step(K_FLAGS, "crit pulse",     5'b01001, 3, 0, 0);
      add_step(K_FLAGS, "crit off",       5'b00001, 4, 0, 0);
      add_step(K_READ,  "crit latched",   0, 0, 32'h0200_0000, 32'h0200_0000);
      add_step(K_WRITE, "mac clear",      0, 32'h400, 32'h400, 0);
      add_step(K_WRITE, "mac clear off",  0, 0, 0, 0);
      add_step(K_READ,  "crit cleared",   0, 0, 0, 32'h0200_0000);
      add_step(K_WRITE, "checker on",     0, 1, 1, 0);
      add_step(K_FLAGS, "hunting",        5'b00001, 40, 0, 0);
      add_step(K_FLAGS, "locked",         5'b10001, 2, 0, 0);
      add_step(K_LAT,   "latency held",   0, 0, 0, 32'h000F_FFF0);
      add_step(K_WRITE, "checker off",    0, 0, 0, 0);
      add_step(K_FLAGS, "unlocked",       5'b00001, 2, 0, 0);
      add_step(K_READ,  "latency zero",   0, 0, 0, 32'h000F_FFF0);
      add_step(K_ACT,   "activity up",    1, 0, 0, 0);
      add_step(K_FLAGS, "link down",      5'b00000, 3, 0, 0);
      add_step(K_ACT,   "activity down",  0, 0, 0, 0);
      add_step(K_PKT,   "packet dropped", 0, 0, 0, 0);
      add_step(K_PKT,   "drop link rise", 2, 0, 0, 0);
      add_step(K_PKT,   "packet after",   1, 0, 0, 0);
   endtask

   initial begin
      logic [31:0] rd;
      logic [31:0] rd2;
      int          err0;
      errors = 0;
      tests_ok = 0;
      tests_bad = 0;
      lfsr_q = 16'd24;
      reset_i = 1'b1;
      {s_tdata_i, s_tuser_i, s_tlast_i, s_tvalid_i, m_tready_i} = '0;
      {wb_adr_i, wb_dat_i, wb_cyc_i, wb_stb_i, wb_we_i} = '0;
      set_flags(5'b00000);
      overruns_i   = 32'h1234_5678;
      cksum_errs_i = 32'h0000_0ABC;
      bist_samps_i = 48'h0123_4567_89AB;
      bist_errs_i  = 48'hFEDC_BA98_7654;
      build_table();
      repeat (16) @(negedge bus_clk);
      reset_i = 1'b0;
      check_value("reset outputs", 0, {wb_ack_o, activity_o, link_up_o, mac_clear_o,
                  phy_reset_o, bist_loopback_o, bist_gen_en_o, bist_checker_en_o,
                  bist_gen_rate_o});
      for (int i = 0; i < n_steps; i++) begin
         err0 = errors;
         case (kind_t[i])
            K_FLAGS: begin
               set_flags(a_t[i][4:0]);
               repeat (d_t[i]) @(negedge bus_clk);  // Synchronizer settling
               check_value({name_t[i], " link up output"}, a_t[i][0], link_up_o);
            end
            K_WRITE: begin
               wb_access(name_t[i], 1'b1, a_t[i][7:0], d_t[i], rd);
               check_value(name_t[i], exp_t[i], {mac_clear_o, phy_reset_o, bist_gen_rate_o,
                           bist_loopback_o, bist_gen_en_o, bist_checker_en_o});
            end
            K_READ: begin
               wb_access(name_t[i], 1'b0, a_t[i][7:0], 0, rd);
               check_value(name_t[i], exp_t[i], rd & mask_t[i]);
            end
            K_PKT: send_packet(name_t[i], a_t[i]);
            K_ACT: check_activity(name_t[i], a_t[i]);
            default: begin
               wb_access(name_t[i], 1'b0, 0, 0, rd);
               repeat (3) @(negedge bus_clk);
               wb_access(name_t[i], 1'b0, 0, 0, rd2);
               check_value(name_t[i], rd & mask_t[i], rd2 & mask_t[i]);
               check_value({name_t[i], " nonzero"}, 1, (rd & mask_t[i]) != 0);
            end
         endcase
         if (errors == err0) begin
            tests_ok++;
            $display("test %s: ok", name_t[i]);
         end else begin
            tests_bad++;
            $display("test %s: failed", name_t[i]);
         end
      end
      $display("tests ok %0d, tests failed %0d, check errors %0d", tests_ok, tests_bad, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // Overall watchdog
   initial begin
      #200000;
      $display("Simulation ran out of time");
      $display("*** FAILED ***");
      $finish;
   end

endmodule
